/* compile.f */
rs_pkg.sv
rs_reg_trk.sv
rs_entry.sv
rs_slot_select.sv
rs_csr_apb.sv
rs_top.sv
rs_chk.sv
tb_rs_check.sv
tb_rs.sv

/* run.sh */
#!/bin/sh
# Build and run the reservation station testbench with Verilator

verilator --binary --timing --assert -Wno-fatal --top-module tb_rs -f compile.f -o tb_rs_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_rs_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qxF "PASS: all tests"; then
    exit 0
fi
exit 1

/* tb_rs.sv */
`timescale 1ns/1ns

module tb_rs;

import rs_pkg::*;

localparam int n_rows     = 12;
localparam int wait_limit = 200;

logic                  clk = 1'b0;
logic                  reset;
logic                  alloc_valid;
logic [opc_w-1:0]      alloc_opcode;
logic [rob_id_w-1:0]   alloc_robid;
logic                  src1_from_rob;
logic [rob_id_w-1:0]   src1_robid;
logic                  src2_is_imm;
t_src2_field           src2_field;
logic [xlen-1:0]       rd_data1;
logic [xlen-1:0]       rd_data2;
logic                  alloc_ready;
logic                  rob_valid;
logic [rob_id_w-1:0]   rob_robid;
logic [xlen-1:0]       rob_result;
logic                  issue_valid;
logic [opc_w-1:0]      issue_opcode;
logic [rob_id_w-1:0]   issue_robid;
logic [xlen-1:0]       issue_src1;
logic [xlen-1:0]       issue_src2;
logic                  issue_ready = 1'b0;
logic                  psel;
logic                  penable;
logic                  pwrite;
logic [apb_addr_w-1:0] paddr;
logic [xlen-1:0]       pwdata;
logic [xlen-1:0]       prdata;
logic                  pready;

int          check_errors;
int          issues_seen;
int          outstanding;
int          tb_errors = 0;
int          ready_mode = 0;
logic [31:0] lfsr_state = 32'h24c1;

// Stimulus table, one row per micro-op, the row index is its ROB id
logic [opc_w-1:0]    t_opc     [n_rows];
logic                t_s1_rob  [n_rows];
logic [rob_id_w-1:0] t_s1_id   [n_rows];
logic [xlen-1:0]     t_v1      [n_rows];
logic [1:0]          t_s2_kind [n_rows];
logic [rob_id_w-1:0] t_s2_id   [n_rows];
logic [xlen-1:0]     t_v2      [n_rows];
logic                t_same    [n_rows];

rs_top dut_i (.*);

tb_rs_check check_i (.*);

always #2 clk = ~clk;

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// Execution unit: 0 stalls, 1 always ready, 2 random
always @(posedge clk) begin
    if (ready_mode == 2) begin
        lfsr_state = lfsr_next(lfsr_state);
        issue_ready <= lfsr_state[0];
    end else begin
        issue_ready <= (ready_mode == 1);
    end
end

task automatic set_row(input int r, input logic [opc_w-1:0] opc, input logic s1_rob,
                       input logic [rob_id_w-1:0] s1_id, input logic [xlen-1:0] v1,
                       input logic [1:0] s2_kind, input logic [rob_id_w-1:0] s2_id,
                       input logic [xlen-1:0] v2, input logic same);
    t_opc[r]     = opc;
    t_s1_rob[r]  = s1_rob;
    t_s1_id[r]   = s1_id;
    t_v1[r]      = v1;
    t_s2_kind[r] = s2_kind;
    t_s2_id[r]   = s2_id;
    t_v2[r]      = v2;
    t_same[r]    = same;
endtask

task automatic check_value(input string name, input logic [xlen-1:0] got,
                           input logic [xlen-1:0] exp);
    if (got !== exp) begin
        tb_errors++;
        $display("mismatch %s: got %h expected %h", name, got, exp);
    end
endtask

task automatic wait_alloc_ready();
    int n = 0;
    @(posedge clk);
    while (!alloc_ready && n < wait_limit) begin
        @(posedge clk);
        n++;
    end
    if (!alloc_ready) begin
        tb_errors++;
        $display("timeout waiting for a free reservation station entry");
    end
endtask

task automatic wait_drained();
    int n = 0;
    @(posedge clk);
    while (outstanding != 0 && n < wait_limit) begin
        @(posedge clk);
        n++;
    end
    if (outstanding != 0) begin
        tb_errors++;
        $display("timeout waiting for %0d micro-ops to issue", outstanding);
    end
endtask

task automatic dispatch_row(input int r);
    t_src2_field         f;
    logic [rob_id_w-1:0] late_id  [2];
    logic [xlen-1:0]     late_val [2];
    int                  n_late = 0;
    wait_alloc_ready();
    f = '0;
    if (t_s2_kind[r] == 2'd2) begin
        f.imm = t_v2[r];
    end else begin
        f.reg_ref.from_rob = (t_s2_kind[r] == 2'd1);
        f.reg_ref.robid    = t_s2_id[r];
    end
    if (t_s1_rob[r]) begin
        late_id[n_late]  = t_s1_id[r];
        late_val[n_late] = t_v1[r];
        n_late++;
    end
    if (t_s2_kind[r] == 2'd1) begin
        late_id[n_late]  = t_s2_id[r];
        late_val[n_late] = t_v2[r];
        n_late++;
    end
    alloc_valid   <= 1'b1;
    alloc_opcode  <= t_opc[r];
    alloc_robid   <= rob_id_w'(r);
    src1_from_rob <= t_s1_rob[r];
    src1_robid    <= t_s1_id[r];
    src2_is_imm   <= (t_s2_kind[r] == 2'd2);
    src2_field    <= f;
    // Register file reads the complement when the value must not be used
    rd_data1 <= t_s1_rob[r] ? ~t_v1[r] : t_v1[r];
    rd_data2 <= (t_s2_kind[r] == 2'd0) ? t_v2[r] : ~t_v2[r];
    if (t_same[r] && n_late > 0) begin
        rob_valid  <= 1'b1;
        rob_robid  <= late_id[0];
        rob_result <= late_val[0];
    end
    @(posedge clk);
    alloc_valid <= 1'b0;
    rob_valid   <= 1'b0;
    for (int i = (t_same[r] ? 1 : 0); i < n_late; i++) begin
        repeat (2) @(posedge clk);
        rob_valid  <= 1'b1;
        rob_robid  <= late_id[i];
        rob_result <= late_val[i];
        @(posedge clk);
        rob_valid <= 1'b0;
    end
endtask

task automatic apb_access(input logic wr, input logic [apb_addr_w-1:0] addr,
                          input logic [xlen-1:0] wdata, output logic [xlen-1:0] rdata);
    int n = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    while (!pready && n < wait_limit) begin
        @(posedge clk);
        n++;
    end
    if (!pready) begin
        tb_errors++;
        $display("timeout waiting for pready on an APB access");
    end
    rdata = prdata;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
endtask

task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [xlen-1:0] data);
    logic [xlen-1:0] unused;
    apb_access(1'b1, addr, data, unused);
endtask

task automatic apb_read(input logic [apb_addr_w-1:0] addr, output logic [xlen-1:0] data);
    apb_access(1'b0, addr, '0, data);
endtask

initial begin
    int              base;
    logic [xlen-1:0] rd;
    reset         = 1'b1;
    alloc_valid   = 1'b0;
    alloc_opcode  = '0;
    alloc_robid   = '0;
    src1_from_rob = 1'b0;
    src1_robid    = '0;
    src2_is_imm   = 1'b0;
    src2_field    = '0;
    rd_data1      = '0;
    rd_data2      = '0;
    rob_valid     = 1'b0;
    rob_robid     = '0;
    rob_result    = '0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    // row, opcode, src1 from ROB, src1 id, src1 value, src2 kind (0 reg, 1 ROB, 2 imm),
    // src2 id, src2 value, first broadcast in the allocation cycle
    set_row(0,  6'h01, 1'b0, 5'd0,  32'h1111_0001, 2'd0, 5'd0,  32'h2222_0001, 1'b0);
    set_row(1,  6'h02, 1'b0, 5'd0,  32'h1111_0002, 2'd2, 5'd0,  32'hffff_ffe0, 1'b0);
    set_row(2,  6'h03, 1'b1, 5'd16, 32'ha5a5_0003, 2'd2, 5'd0,  32'h0000_0027, 1'b0);
    set_row(3,  6'h04, 1'b0, 5'd0,  32'h1111_0004, 2'd1, 5'd17, 32'h5a5a_0004, 1'b1);
    set_row(4,  6'h05, 1'b1, 5'd18, 32'hc3c3_0005, 2'd1, 5'd19, 32'h3c3c_0005, 1'b1);
    set_row(5,  6'h06, 1'b1, 5'd20, 32'h0f0f_0006, 2'd0, 5'd0,  32'h2222_0006, 1'b0);
    set_row(6,  6'h07, 1'b0, 5'd0,  32'h1111_0007, 2'd0, 5'd0,  32'h2222_0007, 1'b0);
    set_row(7,  6'h08, 1'b0, 5'd0,  32'h1111_0008, 2'd2, 5'd0,  32'h8000_0020, 1'b0);
    set_row(8,  6'h09, 1'b0, 5'd0,  32'h1111_0009, 2'd0, 5'd0,  32'h2222_0009, 1'b0);
    set_row(9,  6'h0a, 1'b0, 5'd0,  32'h1111_000a, 2'd2, 5'd0,  32'h0000_003f, 1'b0);
    set_row(10, 6'h0b, 1'b0, 5'd0,  32'h1111_000b, 2'd0, 5'd0,  32'h2222_000b, 1'b0);
    set_row(11, 6'h0c, 1'b1, 5'd21, 32'h9999_000c, 2'd0, 5'd0,  32'h2222_000c, 1'b0);
    repeat (4) @(posedge clk);
    reset      <= 1'b0;
    ready_mode <= 2;

    // Ready operands and wakeups under a random issue_ready
    for (int r = 0; r < 6; r++) begin
        dispatch_row(r);
    end
    wait_drained();

    // Fill the station while the execution unit stalls
    ready_mode <= 0;
    repeat (2) @(posedge clk);
    for (int r = 6; r < 10; r++) begin
        dispatch_row(r);
    end
    // Station stays full with an issue on offer for the whole stall
    for (int c = 0; c < 4; c++) begin
        @(posedge clk);
        check_value("alloc_ready", alloc_ready, 1'b0);
        check_value("issue_valid", issue_valid, 1'b1);
    end
    ready_mode <= 1;
    wait_drained();

    // Issue disabled over APB
    apb_write(ctrl_addr, 32'h0);
    base = issues_seen;
    dispatch_row(10);
    dispatch_row(11);
    repeat (4) @(posedge clk);
    check_value("issue_valid", issue_valid, 1'b0);
    check_value("issues while disabled", issues_seen, base);
    apb_read(status_addr, rd);
    check_value("prdata status", rd, 2);
    apb_write(ctrl_addr, 32'h1);
    ready_mode <= 2;
    wait_drained();

    // Issue counter and its clear
    apb_read(count_addr, rd);
    check_value("prdata count", rd, issues_seen);
    check_value("issues_seen", issues_seen, n_rows);
    apb_write(count_addr, 32'h0);
    apb_read(count_addr, rd);
    check_value("prdata count after clear", rd, 0);

    repeat (2) @(posedge clk);
    $display("errors: checker %0d, testbench %0d, issues seen %0d",
             check_errors, tb_errors, issues_seen);
    if (check_errors == 0 && tb_errors == 0) begin
        $display("PASS: all tests");
    end else begin
        $display("FAIL: see errors above");
    end
    $finish;
end

endmodule

/* tb_rs_check.sv */
`timescale 1ns/1ns

module tb_rs_check (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        alloc_valid,
    input  logic                        alloc_ready,
    input  logic [rs_pkg::opc_w-1:0]    alloc_opcode,
    input  logic [rs_pkg::rob_id_w-1:0] alloc_robid,
    input  logic                        src1_from_rob,
    input  logic [rs_pkg::rob_id_w-1:0] src1_robid,
    input  logic                        src2_is_imm,
    input  rs_pkg::t_src2_field         src2_field,
    input  logic [rs_pkg::xlen-1:0]     rd_data1,
    input  logic [rs_pkg::xlen-1:0]     rd_data2,
    input  logic                        rob_valid,
    input  logic [rs_pkg::rob_id_w-1:0] rob_robid,
    input  logic [rs_pkg::xlen-1:0]     rob_result,
    input  logic                        issue_valid,
    input  logic                        issue_ready,
    input  logic [rs_pkg::opc_w-1:0]    issue_opcode,
    input  logic [rs_pkg::rob_id_w-1:0] issue_robid,
    input  logic [rs_pkg::xlen-1:0]     issue_src1,
    input  logic [rs_pkg::xlen-1:0]     issue_src2,
    output int                          check_errors,
    output int                          issues_seen,
    output int                          outstanding
);

import rs_pkg::*;

localparam int n_ids = 2 ** rob_id_w;

// Expected micro-ops, indexed by their own ROB id
logic                busy    [n_ids];
logic [opc_w-1:0]    exp_opc [n_ids];
logic [xlen-1:0]     exp_src [n_ids][2];
logic                pend    [n_ids][2];
logic [rob_id_w-1:0] wait_id [n_ids][2];
int                  n_err   = 0;
int                  n_issue = 0;
int                  n_out   = 0;

task automatic compare_field(input string name, input logic [rob_id_w-1:0] id,
                             input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
    if (got !== exp) begin
        n_err++;
        $display("mismatch %s for rob id %0d: got %h expected %h", name, id, got, exp);
    end
endtask

always @(posedge clk) begin : model
    logic                s_rob  [2];
    logic [rob_id_w-1:0] s_id   [2];
    logic [xlen-1:0]     s_data [2];
    logic [rob_id_w-1:0] id;
    if (reset) begin
        for (int i = 0; i < n_ids; i++) begin
            busy[i] = 1'b0;
        end
        n_issue = 0;
        n_out   = 0;
    end else begin
        if (issue_valid && issue_ready) begin
            n_issue++;
            id = issue_robid;
            if (!busy[id]) begin
                n_err++;
                $display("issue of rob id %0d which has no outstanding micro-op", id);
            end else begin
                if (pend[id][0] || pend[id][1]) begin
                    n_err++;
                    $display("rob id %0d issued before its operand was broadcast", id);
                end
                compare_field("issue_opcode", id, xlen'(issue_opcode), xlen'(exp_opc[id]));
                compare_field("issue_src1", id, issue_src1, exp_src[id][0]);
                compare_field("issue_src2", id, issue_src2, exp_src[id][1]);
                busy[id] = 1'b0;
                n_out--;
            end
        end
        // Broadcast fills every source still waiting on that id
        if (rob_valid) begin
            for (int i = 0; i < n_ids; i++) begin
                for (int s = 0; s < 2; s++) begin
                    if (busy[i] && pend[i][s] && wait_id[i][s] == rob_robid) begin
                        exp_src[i][s] = rob_result;
                        pend[i][s]    = 1'b0;
                    end
                end
            end
        end
        if (alloc_valid && alloc_ready) begin
            s_rob[0]  = src1_from_rob;
            s_id[0]   = src1_robid;
            s_data[0] = rd_data1;
            if (src2_is_imm) begin
                s_rob[1]  = 1'b0;
                s_id[1]   = '0;
                s_data[1] = src2_field.imm;
            end else begin
                s_rob[1]  = src2_field.reg_ref.from_rob;
                s_id[1]   = src2_field.reg_ref.robid;
                s_data[1] = rd_data2;
            end
            id = alloc_robid;
            if (busy[id]) begin
                n_err++;
                $display("allocation reused rob id %0d while it was outstanding", id);
            end
            busy[id]    = 1'b1;
            exp_opc[id] = alloc_opcode;
            n_out++;
            // Same-cycle broadcast counts as ready at allocation
            for (int s = 0; s < 2; s++) begin
                wait_id[id][s] = s_id[s];
                pend[id][s]    = s_rob[s] && !(rob_valid && rob_robid == s_id[s]);
                exp_src[id][s] = s_rob[s] ? rob_result : s_data[s];
            end
        end
    end
    check_errors <= n_err;
    issues_seen  <= n_issue;
    outstanding  <= n_out;
end

endmodule

/* rs_chk.sv */
`timescale 1ns/1ns

module rs_chk (
    input logic                          clk,
    input logic                          reset,
    input logic [rs_pkg::rs_entries-1:0] req,
    input logic [rs_pkg::rs_entries-1:0] grant,
    input logic                          issue_valid,
    input logic                          issue_ready,
    input rs_pkg::t_entry_sel            issue_sel
);

// A stalled issue keeps offering the same entry
a_sel_hold: assert property (@(posedge clk) disable iff (reset)
    issue_valid && !issue_ready |=> issue_sel == $past(issue_sel))
    else $error("issue_sel moved to entry %0d while the issue was stalled", issue_sel);

a_grant_req: assert property (@(posedge clk) disable iff (reset) (grant & ~req) == '0)
    else $error("grant %b went to an entry that is not requesting, req %b", grant, req);

// A stalled issue stays up until the execution unit takes it
a_issue_hold: assert property (@(posedge clk) disable iff (reset)
    issue_valid && !issue_ready |=> issue_valid)
    else $error("issue_valid dropped while issue_ready was low");

endmodule

bind rs_slot_select rs_chk chk_i (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .grant       (grant),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_sel   (issue_sel)
);

/* rs_top.sv */
`timescale 1ns/1ns

module rs_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          alloc_valid,
    input  logic [rs_pkg::opc_w-1:0]      alloc_opcode,
    input  logic [rs_pkg::rob_id_w-1:0]   alloc_robid,
    input  logic                          src1_from_rob,
    input  logic [rs_pkg::rob_id_w-1:0]   src1_robid,
    input  logic                          src2_is_imm,
    input  rs_pkg::t_src2_field           src2_field,
    input  logic [rs_pkg::xlen-1:0]       rd_data1,
    input  logic [rs_pkg::xlen-1:0]       rd_data2,
    output logic                          alloc_ready,
    input  logic                          rob_valid,
    input  logic [rs_pkg::rob_id_w-1:0]   rob_robid,
    input  logic [rs_pkg::xlen-1:0]       rob_result,
    output logic                          issue_valid,
    output logic [rs_pkg::opc_w-1:0]      issue_opcode,
    output logic [rs_pkg::rob_id_w-1:0]   issue_robid,
    output logic [rs_pkg::xlen-1:0]       issue_src1,
    output logic [rs_pkg::xlen-1:0]       issue_src2,
    input  logic                          issue_ready,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [rs_pkg::apb_addr_w-1:0] paddr,
    input  logic [rs_pkg::xlen-1:0]       pwdata,
    output logic [rs_pkg::xlen-1:0]       prdata,
    output logic                          pready
);

import rs_pkg::*;

logic [rs_entries-1:0] ent_valid;
logic [rs_entries-1:0] ent_req;
logic [rs_entries-1:0] ent_grant;
logic [rs_entries-1:0] ent_alloc;
logic [opc_w-1:0]      ent_opcode [rs_entries];
logic [rob_id_w-1:0]   ent_robid  [rs_entries];
logic [xlen-1:0]       ent_src1   [rs_entries];
logic [xlen-1:0]       ent_src2   [rs_entries];
t_entry_sel            issue_sel;
logic                  issue_fire;
logic                  issue_enable;

for (genvar e = 0; e < rs_entries; e++) begin : g_entry
    rs_entry u_entry (
        .clk           (clk),
        .reset         (reset),
        .alloc         (ent_alloc[e]),
        .alloc_opcode  (alloc_opcode),
        .alloc_robid   (alloc_robid),
        .src1_from_rob (src1_from_rob),
        .src1_robid    (src1_robid),
        .src2_is_imm   (src2_is_imm),
        .src2_field    (src2_field),
        .rd_data1      (rd_data1),
        .rd_data2      (rd_data2),
        .rob_valid     (rob_valid),
        .rob_robid     (rob_robid),
        .rob_result    (rob_result),
        .grant         (ent_grant[e]),
        .valid         (ent_valid[e]),
        .req           (ent_req[e]),
        .entry_opcode  (ent_opcode[e]),
        .entry_robid   (ent_robid[e]),
        .entry_src1    (ent_src1[e]),
        .entry_src2    (ent_src2[e])
    );
end

rs_slot_select u_select (
    .clk          (clk),
    .reset        (reset),
    .req          (ent_req),
    .valid        (ent_valid),
    .issue_enable (issue_enable),
    .issue_ready  (issue_ready),
    .alloc_valid  (alloc_valid),
    .grant        (ent_grant),
    .alloc_onehot (ent_alloc),
    .alloc_ready  (alloc_ready),
    .issue_valid  (issue_valid),
    .issue_sel    (issue_sel),
    .issue_fire   (issue_fire)
);

rs_csr_apb u_csr (
    .clk          (clk),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .valid        (ent_valid),
    .issue_fire   (issue_fire),
    .issue_enable (issue_enable)
);

// Issue payload straight from the selected entry
assign issue_opcode = ent_opcode[issue_sel];
assign issue_robid  = ent_robid[issue_sel];
assign issue_src1   = ent_src1[issue_sel];
assign issue_src2   = ent_src2[issue_sel];

endmodule

/* rs_csr_apb.sv */
`timescale 1ns/1ns

module rs_csr_apb (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [rs_pkg::apb_addr_w-1:0] paddr,
    input  logic [rs_pkg::xlen-1:0]       pwdata,
    output logic [rs_pkg::xlen-1:0]       prdata,
    output logic                          pready,
    input  logic [rs_pkg::rs_entries-1:0] valid,
    input  logic                          issue_fire,
    output logic                          issue_enable
);

import rs_pkg::*;

logic            apb_wr;
logic [occ_w-1:0] occupancy;
logic [xlen-1:0] issue_count;

// No wait states
assign pready = 1'b1;

// Writes land in the access phase
assign apb_wr = psel && penable && pwrite;

always_ff @(posedge clk) begin
    if (reset) begin
        issue_enable <= 1'b1;
        issue_count  <= '0;
    end else begin
        if (apb_wr && paddr == ctrl_addr) begin
            issue_enable <= pwdata[ctrl_issue_en_bit];
        end
        // Clear wins over a same-cycle issue
        if (apb_wr && paddr == count_addr) begin
            issue_count <= '0;
        end else if (issue_fire) begin
            issue_count <= issue_count + 1'b1;
        end
    end
end

// Number of busy entries
always_comb begin
    occupancy = '0;
    for (int i = 0; i < rs_entries; i++) begin
        occupancy = occupancy + occ_w'(valid[i]);
    end
end

always_comb begin
    prdata = '0;
    case (paddr)
        ctrl_addr:   prdata[ctrl_issue_en_bit] = issue_enable;
        status_addr: prdata = xlen'(occupancy);
        count_addr:  prdata = issue_count;
        default:     prdata = '0;
    endcase
end

endmodule

/* rs_slot_select.sv */
`timescale 1ns/1ns

module rs_slot_select (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rs_pkg::rs_entries-1:0] req,
    input  logic [rs_pkg::rs_entries-1:0] valid,
    input  logic                          issue_enable,
    input  logic                          issue_ready,
    input  logic                          alloc_valid,
    output logic [rs_pkg::rs_entries-1:0] grant,
    output logic [rs_pkg::rs_entries-1:0] alloc_onehot,
    output logic                          alloc_ready,
    output logic                          issue_valid,
    output rs_pkg::t_entry_sel            issue_sel,
    output logic                          issue_fire
);

import rs_pkg::*;

t_entry_sel rr_ptr;
t_entry_sel scan_idx;
t_entry_sel pick_sel;
logic       pick_found;
logic       hold;
t_entry_sel hold_sel;
logic       free_found;

// First requester at or after the round-robin pointer
always_comb begin
    pick_found = 1'b0;
    pick_sel   = rr_ptr;
    scan_idx   = rr_ptr;
    for (int i = 0; i < rs_entries; i++) begin
        scan_idx = t_entry_sel'(rr_ptr + i);
        if (!pick_found && req[scan_idx]) begin
            pick_found = 1'b1;
            pick_sel   = scan_idx;
        end
    end
end

// A stalled issue keeps pointing at the same entry until it is taken
assign issue_sel   = hold ? hold_sel : pick_sel;
assign issue_valid = issue_enable && (hold || pick_found);
assign issue_fire  = issue_valid && issue_ready;

always_comb begin
    for (int i = 0; i < rs_entries; i++) begin
        grant[i] = issue_fire && (issue_sel == t_entry_sel'(i));
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        rr_ptr <= '0;
        hold   <= 1'b0;
    end else begin
        hold <= issue_valid && !issue_ready;
        if (issue_fire) begin
            rr_ptr <= t_entry_sel'(issue_sel + 1'b1);
        end
    end
end

always_ff @(posedge clk) begin
    if (issue_valid) begin
        hold_sel <= issue_sel;
    end
end

// Lowest idle entry takes the next dispatch
always_comb begin
    free_found   = 1'b0;
    alloc_onehot = '0;
    for (int i = 0; i < rs_entries; i++) begin
        if (!valid[i] && !free_found) begin
            alloc_onehot[i] = alloc_valid;
            free_found      = 1'b1;
        end
    end
end

assign alloc_ready = !(&valid);

endmodule

/* rs_entry.sv */
`timescale 1ns/1ns

module rs_entry (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        alloc,
    input  logic [rs_pkg::opc_w-1:0]    alloc_opcode,
    input  logic [rs_pkg::rob_id_w-1:0] alloc_robid,
    input  logic                        src1_from_rob,
    input  logic [rs_pkg::rob_id_w-1:0] src1_robid,
    input  logic                        src2_is_imm,
    input  rs_pkg::t_src2_field         src2_field,
    input  logic [rs_pkg::xlen-1:0]     rd_data1,
    input  logic [rs_pkg::xlen-1:0]     rd_data2,
    input  logic                        rob_valid,
    input  logic [rs_pkg::rob_id_w-1:0] rob_robid,
    input  logic [rs_pkg::xlen-1:0]     rob_result,
    input  logic                        grant,
    output logic                        valid,
    output logic                        req,
    output logic [rs_pkg::opc_w-1:0]    entry_opcode,
    output logic [rs_pkg::rob_id_w-1:0] entry_robid,
    output logic [rs_pkg::xlen-1:0]     entry_src1,
    output logic [rs_pkg::xlen-1:0]     entry_src2
);

import rs_pkg::*;

typedef enum logic {
    IDLE,
    VALID
} t_ent_state;

t_ent_state state;

logic [num_srcs-1:0] src_ready;
logic                src2_from_rob;
logic [rob_id_w-1:0] src2_robid;
logic [xlen-1:0]     src2_data;

always_ff @(posedge clk) begin
    if (reset) begin
        state <= IDLE;
    end else begin
        case (state)
            IDLE:    if (alloc) state <= VALID;
            VALID:   if (grant) state <= IDLE;
            default: state <= IDLE;
        endcase
    end
end

assign valid = (state == VALID);

// Static micro-op fields
always_ff @(posedge clk) begin
    if (alloc) begin
        entry_opcode <= alloc_opcode;
        entry_robid  <= alloc_robid;
    end
end

// Second source decode, immediate goes in as ready data
always_comb begin
    if (src2_is_imm) begin
        src2_from_rob = 1'b0;
        src2_robid    = '0;
        src2_data     = src2_field.imm;
    end else begin
        src2_from_rob = src2_field.reg_ref.from_rob;
        src2_robid    = src2_field.reg_ref.robid;
        src2_data     = rd_data2;
    end
end

rs_reg_trk u_trk_src1 (
    .clk        (clk),
    .reset      (reset),
    .alloc      (alloc),
    .from_rob   (src1_from_rob),
    .robid      (src1_robid),
    .rd_data    (rd_data1),
    .rob_valid  (rob_valid),
    .rob_robid  (rob_robid),
    .rob_result (rob_result),
    .ready      (src_ready[0]),
    .src_data   (entry_src1)
);

rs_reg_trk u_trk_src2 (
    .clk        (clk),
    .reset      (reset),
    .alloc      (alloc),
    .from_rob   (src2_from_rob),
    .robid      (src2_robid),
    .rd_data    (src2_data),
    .rob_valid  (rob_valid),
    .rob_robid  (rob_robid),
    .rob_result (rob_result),
    .ready      (src_ready[1]),
    .src_data   (entry_src2)
);

assign req = valid && (&src_ready);

endmodule

/* rs_reg_trk.sv */
`timescale 1ns/1ns

module rs_reg_trk (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        alloc,
    input  logic                        from_rob,
    input  logic [rs_pkg::rob_id_w-1:0] robid,
    input  logic [rs_pkg::xlen-1:0]     rd_data,
    input  logic                        rob_valid,
    input  logic [rs_pkg::rob_id_w-1:0] rob_robid,
    input  logic [rs_pkg::xlen-1:0]     rob_result,
    output logic                        ready,
    output logic [rs_pkg::xlen-1:0]     src_data
);

import rs_pkg::*;

logic [rob_id_w-1:0] wait_id;
logic                alloc_hit;
logic                wait_hit;

// Broadcast against the id being allocated right now
assign alloc_hit = rob_valid && (rob_robid == robid);

// Broadcast against the id we are already parked on
assign wait_hit = rob_valid && (rob_robid == wait_id);

always_ff @(posedge clk) begin
    if (reset) begin
        ready <= 1'b0;
    end else if (alloc) begin
        // Register or immediate data is ready at once, so is a same-cycle wakeup
        ready <= !from_rob || alloc_hit;
    end else if (!ready && wait_hit) begin
        ready <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (alloc) begin
        wait_id  <= robid;
        src_data <= from_rob ? rob_result : rd_data;
    end else if (!ready && wait_hit) begin
        src_data <= rob_result;
    end
end

endmodule

/* rs_pkg.sv */
package rs_pkg;

// Reservation station geometry
localparam int rs_entries = 4;
localparam int num_srcs   = 2;

// Dispatch and issue field widths
localparam int rob_id_w = 5;
localparam int xlen     = 32;
localparam int opc_w    = 6;

// Occupancy has to count from zero up to a full station
localparam int occ_w = $clog2(rs_entries + 1);

// APB register map
localparam int apb_addr_w = 4;

localparam logic [apb_addr_w-1:0] ctrl_addr   = 4'h0;
localparam logic [apb_addr_w-1:0] status_addr = 4'h4;
localparam logic [apb_addr_w-1:0] count_addr  = 4'h8;

// Bit 0 of the control register
localparam int ctrl_issue_en_bit = 0;

// Entry index
typedef logic [$clog2(rs_entries)-1:0] t_entry_sel;

// Register view of the second source field
typedef struct packed {
    logic [xlen-rob_id_w-2:0] pad;
    logic                     from_rob;
    logic [rob_id_w-1:0]      robid;
} t_src2_reg;

// Second source as dispatched, src2_is_imm picks the view
typedef union packed {
    t_src2_reg         reg_ref;
    logic [xlen-1:0]   imm;
} t_src2_field;

endpackage
